//--- Makefile
TOOL       := verilator
FLAGS      := --binary --timing --timescale 1ns/1ps
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
TOP        := tb_rv_exec
RTL_TOP    := rv_exec_top
FILELIST   := vlog.f
LOG        := sim.log
FAIL_MSG   := Test failed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf obj_dir $(LOG)

//--- hw/alu_exec.sv
module alu_exec (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 d_valid,
  input  rv_isa_pkg::alu_op_t  d_op,
  input  rv_isa_pkg::reg_idx_t d_rd,
  input  rv_isa_pkg::reg_idx_t d_rs1,
  input  rv_isa_pkg::reg_idx_t d_rs2,
  input  rv_isa_pkg::xlen_t    d_a,
  input  rv_isa_pkg::xlen_t    d_b,
  input  logic                 d_use_rs2,
  input  logic                 d_illegal,
  input  logic                 stall,
  output logic                 e_valid,
  output rv_isa_pkg::reg_idx_t e_rd,
  output rv_isa_pkg::xlen_t    e_result,
  output logic                 e_illegal
);

  logic              e_writes;
  logic              fwd_a;
  logic              fwd_b;
  logic [4:0]        shamt;
  rv_isa_pkg::xlen_t op_a;
  rv_isa_pkg::xlen_t op_b;
  rv_isa_pkg::xlen_t result;

  // instruction one ahead, still in the execute register
  assign e_writes = e_valid && e_rd != '0 && !e_illegal;
  assign fwd_a    = e_writes && d_rs1 == e_rd;
  assign fwd_b    = e_writes && d_use_rs2 && d_rs2 == e_rd;  // imm never forwarded

  assign op_a  = fwd_a ? e_result : d_a;
  assign op_b  = fwd_b ? e_result : d_b;
  assign shamt = op_b[4:0];

  always_comb begin
    case (d_op)
      rv_isa_pkg::ALU_ADD:    result = op_a + op_b;
      rv_isa_pkg::ALU_SUB:    result = op_a - op_b;
      rv_isa_pkg::ALU_SLL:    result = op_a << shamt;
      rv_isa_pkg::ALU_SLT:    result = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_isa_pkg::ALU_SLTU:   result = {31'b0, op_a < op_b};
      rv_isa_pkg::ALU_XOR:    result = op_a ^ op_b;
      rv_isa_pkg::ALU_SRL:    result = op_a >> shamt;
      rv_isa_pkg::ALU_SRA:    result = $signed(op_a) >>> shamt;
      rv_isa_pkg::ALU_OR:     result = op_a | op_b;
      rv_isa_pkg::ALU_AND:    result = op_a & op_b;
      rv_isa_pkg::ALU_PASS_B: result = op_b;
      default:                result = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      e_valid <= 1'b0;
    end else if (!stall) begin
      e_valid <= d_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      e_rd      <= d_rd;
      e_result  <= result;
      e_illegal <= d_illegal;
    end
  end

endmodule

//--- hw/engine_cfg_pkg.sv
package engine_cfg_pkg;

  // intake FIFO, also the host's starting credit count
  localparam int INTAKE_DEPTH = 4;
  localparam int INTAKE_AW    = $clog2(INTAKE_DEPTH);

  typedef logic [INTAKE_AW-1:0] intake_ptr_t;

  // holds 0..4
  typedef logic [2:0] credit_t;

  localparam credit_t WB_CREDITS = 3'd4;  // receiver buffer on the output port

endpackage

//--- hw/inst_decode.sv
module inst_decode (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 head_valid,
  input  rv_isa_pkg::inst_t    head_data,
  input  logic                 stall,
  input  logic                 rf_we,
  input  rv_isa_pkg::reg_idx_t rf_waddr,
  input  rv_isa_pkg::xlen_t    rf_wdata,
  output logic                 head_pop,
  output logic                 d_valid,
  output rv_isa_pkg::alu_op_t  d_op,
  output rv_isa_pkg::reg_idx_t d_rd,
  output rv_isa_pkg::reg_idx_t d_rs1,
  output rv_isa_pkg::reg_idx_t d_rs2,
  output rv_isa_pkg::xlen_t    d_a,
  output rv_isa_pkg::xlen_t    d_b,
  output logic                 d_use_rs2,
  output logic                 d_illegal
);

  rv_isa_pkg::opcode_t  opcode;
  rv_isa_pkg::funct3_t  funct3;
  rv_isa_pkg::reg_idx_t rs1;
  rv_isa_pkg::reg_idx_t rs2;
  rv_isa_pkg::xlen_t    rdata1;
  rv_isa_pkg::xlen_t    rdata2;
  rv_isa_pkg::xlen_t    imm;
  rv_isa_pkg::alu_op_t  op;
  logic                 use_rs1;
  logic                 use_rs2;
  logic                 illegal;

  function automatic rv_isa_pkg::alu_op_t alu_sel(input rv_isa_pkg::funct3_t f3,
                                                  input logic alt);
    case (f3)
      rv_isa_pkg::F3_ADD_SUB: alu_sel = alt ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:     alu_sel = rv_isa_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:     alu_sel = rv_isa_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU:    alu_sel = rv_isa_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:     alu_sel = rv_isa_pkg::ALU_XOR;
      rv_isa_pkg::F3_SRL_SRA: alu_sel = alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:      alu_sel = rv_isa_pkg::ALU_OR;
      default:                alu_sel = rv_isa_pkg::ALU_AND;
    endcase
  endfunction

  assign opcode   = head_data[6:0];
  assign funct3   = head_data[14:12];
  assign rs1      = head_data[19:15];
  assign rs2      = head_data[24:20];
  assign head_pop = head_valid && !stall;

  always_comb begin
    op      = rv_isa_pkg::ALU_PASS_B;  // illegal words end up as value zero
    imm     = '0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    illegal = 1'b1;
    case (opcode)
      rv_isa_pkg::OPCODE_OP: begin
        op      = alu_sel(funct3, head_data[30]);
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        illegal = 1'b0;
      end
      rv_isa_pkg::OPCODE_OP_IMM: begin
        // no subi, bit 30 only picks srai
        op      = alu_sel(funct3, head_data[30] && funct3 == rv_isa_pkg::F3_SRL_SRA);
        imm     = {{20{head_data[31]}}, head_data[31:20]};
        use_rs1 = 1'b1;
        illegal = 1'b0;
      end
      rv_isa_pkg::OPCODE_LUI: begin
        imm     = {head_data[31:12], 12'b0};
        illegal = 1'b0;
      end
      default: ;
    endcase
  end

  reg_file u_reg_file (
    .clk    (clk),
    .arst_n (arst_n),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .we     (rf_we),
    .waddr  (rf_waddr),
    .wdata  (rf_wdata)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      d_valid <= 1'b0;
    end else if (!stall) begin
      d_valid <= head_valid;
    end
  end

  // decode register payload
  always_ff @(posedge clk) begin
    if (!stall) begin
      d_op      <= op;
      d_rd      <= head_data[11:7];
      d_rs1     <= use_rs1 ? rs1 : '0;  // x0 keeps forwarding off for lui
      d_rs2     <= rs2;
      d_a       <= use_rs1 ? rdata1 : '0;
      d_b       <= use_rs2 ? rdata2 : imm;
      d_use_rs2 <= use_rs2;
      d_illegal <= illegal;
    end
  end

endmodule

//--- hw/inst_intake.sv
module inst_intake (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 inst_valid,
  input  rv_isa_pkg::inst_t    inst_data,
  input  logic                 head_pop,
  output logic                 head_valid,
  output rv_isa_pkg::inst_t    head_data,
  output logic                 inst_credit
);

  rv_isa_pkg::inst_t          mem [engine_cfg_pkg::INTAKE_DEPTH];
  engine_cfg_pkg::intake_ptr_t rd_ptr;
  engine_cfg_pkg::intake_ptr_t wr_ptr;
  engine_cfg_pkg::credit_t     count;

  assign head_valid = (count != '0);
  assign head_data  = mem[rd_ptr];

  // storage, no reset needed
  always_ff @(posedge clk) begin
    if (inst_valid) begin
      mem[wr_ptr] <= inst_data;
    end
  end

  // host is credit-bound so a push never meets a full FIFO
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr      <= '0;
      wr_ptr      <= '0;
      count       <= '0;
      inst_credit <= 1'b0;
    end else begin
      inst_credit <= head_pop;  // one credit back per word popped
      if (inst_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (head_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({inst_valid, head_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- hw/reg_file.sv
module reg_file (
  input  logic                 clk,
  input  logic                 arst_n,
  input  rv_isa_pkg::reg_idx_t raddr1,
  input  rv_isa_pkg::reg_idx_t raddr2,
  output rv_isa_pkg::xlen_t    rdata1,
  output rv_isa_pkg::xlen_t    rdata2,
  input  logic                 we,
  input  rv_isa_pkg::reg_idx_t waddr,
  input  rv_isa_pkg::xlen_t    wdata
);

  rv_isa_pkg::xlen_t regs [1:31];  // x0 has no storage

  // write-through on a same-cycle address match
  assign rdata1 = (raddr1 == '0) ? '0 :
                  (we && waddr == raddr1) ? wdata : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 :
                  (we && waddr == raddr2) ? wdata : regs[raddr2];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

//--- hw/rv_exec_top.sv
module rv_exec_top (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 inst_valid,
  input  rv_isa_pkg::inst_t    inst_data,
  input  logic                 wb_credit,
  output logic                 inst_credit,
  output logic                 wb_valid,
  output rv_isa_pkg::reg_idx_t wb_rd,
  output rv_isa_pkg::xlen_t    wb_value,
  output logic                 wb_illegal
);

  logic                 head_valid;
  rv_isa_pkg::inst_t    head_data;
  logic                 head_pop;
  logic                 stall;
  logic                 rf_we;
  rv_isa_pkg::reg_idx_t rf_waddr;
  rv_isa_pkg::xlen_t    rf_wdata;

  // decode register
  logic                 d_valid;
  rv_isa_pkg::alu_op_t  d_op;
  rv_isa_pkg::reg_idx_t d_rd;
  rv_isa_pkg::reg_idx_t d_rs1;
  rv_isa_pkg::reg_idx_t d_rs2;
  rv_isa_pkg::xlen_t    d_a;
  rv_isa_pkg::xlen_t    d_b;
  logic                 d_use_rs2;
  logic                 d_illegal;

  // execute register
  logic                 e_valid;
  rv_isa_pkg::reg_idx_t e_rd;
  rv_isa_pkg::xlen_t    e_result;
  logic                 e_illegal;

  inst_intake u_inst_intake (
    .clk         (clk),
    .arst_n      (arst_n),
    .inst_valid  (inst_valid),
    .inst_data   (inst_data),
    .head_pop    (head_pop),
    .head_valid  (head_valid),
    .head_data   (head_data),
    .inst_credit (inst_credit)
  );

  inst_decode u_inst_decode (
    .clk        (clk),
    .arst_n     (arst_n),
    .head_valid (head_valid),
    .head_data  (head_data),
    .stall      (stall),
    .rf_we      (rf_we),
    .rf_waddr   (rf_waddr),
    .rf_wdata   (rf_wdata),
    .head_pop   (head_pop),
    .d_valid    (d_valid),
    .d_op       (d_op),
    .d_rd       (d_rd),
    .d_rs1      (d_rs1),
    .d_rs2      (d_rs2),
    .d_a        (d_a),
    .d_b        (d_b),
    .d_use_rs2  (d_use_rs2),
    .d_illegal  (d_illegal)
  );

  alu_exec u_alu_exec (
    .clk       (clk),
    .arst_n    (arst_n),
    .d_valid   (d_valid),
    .d_op      (d_op),
    .d_rd      (d_rd),
    .d_rs1     (d_rs1),
    .d_rs2     (d_rs2),
    .d_a       (d_a),
    .d_b       (d_b),
    .d_use_rs2 (d_use_rs2),
    .d_illegal (d_illegal),
    .stall     (stall),
    .e_valid   (e_valid),
    .e_rd      (e_rd),
    .e_result  (e_result),
    .e_illegal (e_illegal)
  );

  wb_sender u_wb_sender (
    .clk        (clk),
    .arst_n     (arst_n),
    .e_valid    (e_valid),
    .e_rd       (e_rd),
    .e_result   (e_result),
    .e_illegal  (e_illegal),
    .wb_credit  (wb_credit),
    .stall      (stall),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_value   (wb_value),
    .wb_illegal (wb_illegal),
    .rf_we      (rf_we),
    .rf_waddr   (rf_waddr),
    .rf_wdata   (rf_wdata)
  );

endmodule

//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

  typedef logic [31:0] xlen_t;     // data word
  typedef logic [31:0] inst_t;     // raw instruction word
  typedef logic [4:0]  reg_idx_t;  // register index
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;

  // major opcodes
  localparam opcode_t OPCODE_OP     = 7'b0110011;
  localparam opcode_t OPCODE_OP_IMM = 7'b0010011;
  localparam opcode_t OPCODE_LUI    = 7'b0110111;

  // funct3 encodings shared by OP and OP-IMM
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10  // lui, operand b straight through
  } alu_op_t;

endpackage

//--- hw/wb_sender.sv
module wb_sender (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 e_valid,
  input  rv_isa_pkg::reg_idx_t e_rd,
  input  rv_isa_pkg::xlen_t    e_result,
  input  logic                 e_illegal,
  input  logic                 wb_credit,
  output logic                 stall,
  output logic                 wb_valid,
  output rv_isa_pkg::reg_idx_t wb_rd,
  output rv_isa_pkg::xlen_t    wb_value,
  output logic                 wb_illegal,
  output logic                 rf_we,
  output rv_isa_pkg::reg_idx_t rf_waddr,
  output rv_isa_pkg::xlen_t    rf_wdata
);

  engine_cfg_pkg::credit_t credits;
  logic                    have_credit;

  assign have_credit = (credits != '0);

  // record waits in the execute register until the receiver has room
  assign stall    = e_valid && !have_credit;
  assign wb_valid = e_valid && have_credit;

  assign wb_rd      = e_rd;
  assign wb_value   = (e_rd != '0) ? e_result : '0;  // x0 records carry zero
  assign wb_illegal = e_illegal;

  // retire into the register file on the same cycle as the record
  assign rf_we    = wb_valid && !e_illegal && e_rd != '0;
  assign rf_waddr = e_rd;
  assign rf_wdata = e_result;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credits <= engine_cfg_pkg::WB_CREDITS;
    end else begin
      case ({wb_valid, wb_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;  // send and return cancel out
      endcase
    end
  end

endmodule

//--- testbench/tb_rv_exec.sv
module tb_rv_exec;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_LIMIT  = 500;   // cycles one word may wait for an input credit
  localparam int DRAIN_LIMIT = 2000;

  logic                 clk         = 1'b0;
  logic                 arst_n      = 1'b0;
  logic                 inst_valid  = 1'b0;
  rv_isa_pkg::inst_t    inst_data   = '0;
  rv_isa_pkg::xlen_t    exp_value   = '0;
  logic                 wb_credit   = 1'b0;
  logic                 final_check = 1'b0;
  logic                 inst_credit;
  logic                 wb_valid;
  rv_isa_pkg::reg_idx_t wb_rd;
  rv_isa_pkg::xlen_t    wb_value;
  logic                 wb_illegal;
  int                   chk_errors;
  int                   records;

  rv_isa_pkg::inst_t tbl_inst [$];
  rv_isa_pkg::xlen_t tbl_value [$];
  int                host_credits = engine_cfg_pkg::INTAKE_DEPTH;
  int                credit_due [$];  // cycle at which each output credit goes back
  int                cycle = 0;
  int                delay;
  int                due;
  integer            seed = 32'he2c743a1;
  int                timeouts = 0;
  logic              timed_out = 1'b0;

  function automatic rv_isa_pkg::inst_t r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                                    input logic [4:0] rs1, input logic [2:0] f3,
                                                    input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPCODE_OP};
  endfunction

  function automatic rv_isa_pkg::inst_t i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                    input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, rv_isa_pkg::OPCODE_OP_IMM};
  endfunction

  function automatic rv_isa_pkg::inst_t lui_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, rv_isa_pkg::OPCODE_LUI};
  endfunction

  task automatic add_entry(input rv_isa_pkg::inst_t word, input rv_isa_pkg::xlen_t value);
    tbl_inst.push_back(word);
    tbl_value.push_back(value);
  endtask

  // instruction word and the value its record must carry
  task automatic load_table();
    add_entry(lui_word(20'h80000, 5'd1), 32'h8000_0000);
    add_entry(i_type_word(12'd100, 5'd0, 3'd0, 5'd2), 32'd100);
    add_entry(i_type_word(12'hff9, 5'd2, 3'd0, 5'd3), 32'd93);          // uses x2 right away
    add_entry(r_type_word(7'h00, 5'd3, 5'd2, 3'd0, 5'd4), 32'd193);
    add_entry(r_type_word(7'h20, 5'd3, 5'd2, 3'd0, 5'd5), 32'd7);       // sub
    add_entry(r_type_word(7'h20, 5'd2, 5'd3, 3'd0, 5'd6), 32'hffff_fff9);
    add_entry(r_type_word(7'h00, 5'd5, 5'd6, 3'd2, 5'd7), 32'd1);       // slt -7 < 7
    add_entry(r_type_word(7'h00, 5'd5, 5'd6, 3'd3, 5'd8), 32'd0);       // sltu sees -7 as large
    add_entry(i_type_word(12'hfff, 5'd6, 3'd2, 5'd9), 32'd1);           // slti -7 < -1
    add_entry(i_type_word(12'hfff, 5'd5, 3'd3, 5'd10), 32'd1);          // sltiu against all ones
    add_entry(r_type_word(7'h00, 5'd5, 5'd4, 3'd4, 5'd11), 32'h0000_00c6);
    add_entry(i_type_word(12'h0ff, 5'd11, 3'd4, 5'd12), 32'h0000_0039);
    add_entry(r_type_word(7'h00, 5'd5, 5'd1, 3'd6, 5'd13), 32'h8000_0007);
    add_entry(i_type_word(12'h700, 5'd5, 3'd6, 5'd14), 32'h0000_0707);
    add_entry(r_type_word(7'h00, 5'd4, 5'd14, 3'd7, 5'd15), 32'h0000_0001);
    add_entry(i_type_word(12'h0f0, 5'd6, 3'd7, 5'd16), 32'h0000_00f0);
    add_entry(r_type_word(7'h00, 5'd2, 5'd5, 3'd1, 5'd17), 32'h0000_0070); // shift by 100 mod 32
    add_entry(i_type_word(12'h01c, 5'd5, 3'd1, 5'd18), 32'h7000_0000);
    add_entry(r_type_word(7'h00, 5'd5, 5'd1, 3'd5, 5'd19), 32'h0100_0000); // srl
    add_entry(r_type_word(7'h20, 5'd5, 5'd1, 3'd5, 5'd20), 32'hff00_0000); // sra keeps the sign
    add_entry(i_type_word(12'h401, 5'd6, 3'd5, 5'd21), 32'hffff_fffc);     // srai by 1
    add_entry(i_type_word(12'h01c, 5'd6, 3'd5, 5'd22), 32'h0000_000f);     // srli by 28
    add_entry(i_type_word(12'd5, 5'd2, 3'd0, 5'd0), 32'd0);               // rd is x0, reports zero
    add_entry(r_type_word(7'h00, 5'd2, 5'd0, 3'd0, 5'd23), 32'd100);      // x0 still reads zero
    add_entry({20'h12345, 5'd23, 7'b0000011}, 32'd0);                     // load opcode is illegal
    add_entry(i_type_word(12'd1, 5'd23, 3'd0, 5'd24), 32'd101);           // x23 untouched
    add_entry(lui_word(20'habcde, 5'd25), 32'habcd_e000);
    add_entry(i_type_word(12'h123, 5'd25, 3'd0, 5'd26), 32'habcd_e123);
  endtask

  // waits for an input credit, then presents one word for a single cycle
  task automatic send_word(input int idx);
    int waited;
    int avail;
    waited = 0;
    @(posedge clk);
    avail = host_credits + int'(inst_credit) - int'(inst_valid);
    while (avail <= 0 && waited < WAIT_LIMIT) begin
      inst_valid <= 1'b0;
      waited++;
      @(posedge clk);
      avail = host_credits + int'(inst_credit) - int'(inst_valid);
    end
    if (avail <= 0) begin
      $display("timeout: no input credit for word %0d after %0d cycles", idx, waited);
      timeouts++;
      timed_out = 1'b1;
    end else begin
      inst_valid <= 1'b1;
      inst_data  <= tbl_inst[idx];
      exp_value  <= tbl_value[idx];
    end
  endtask

  initial begin
    forever #10 clk = ~clk;
  end

  // host side credit count
  always @(posedge clk) begin
    if (arst_n) begin
      host_credits <= host_credits + int'(inst_credit) - int'(inst_valid);
    end
  end

  // receiver frees its buffer after a random delay
  always @(posedge clk) begin
    if (arst_n) begin
      cycle = cycle + 1;
      wb_credit <= 1'b0;
      if (wb_valid) begin
        delay = $unsigned($random(seed)) % 16;
        due   = cycle + 1 + delay;
        if (credit_due.size() > 0 && due <= credit_due[$]) begin
          due = credit_due[$] + 1;  // one pulse per cycle
        end
        credit_due.push_back(due);
      end
      if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
        wb_credit <= 1'b1;
        credit_due.delete(0);
      end
    end
  end

  rv_exec_top u_dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .inst_valid  (inst_valid),
    .inst_data   (inst_data),
    .wb_credit   (wb_credit),
    .inst_credit (inst_credit),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_value    (wb_value),
    .wb_illegal  (wb_illegal)
  );

  wb_checker u_chk (
    .clk         (clk),
    .arst_n      (arst_n),
    .inst_valid  (inst_valid),
    .inst_data   (inst_data),
    .exp_value   (exp_value),
    .inst_credit (inst_credit),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_value    (wb_value),
    .wb_illegal  (wb_illegal),
    .final_check (final_check),
    .errors      (chk_errors),
    .records     (records)
  );

  initial begin
    int i;
    int waited;
    load_table();
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    i = 0;
    while (i < tbl_inst.size() && !timed_out) begin
      send_word(i);
      i++;
    end
    @(posedge clk);
    inst_valid <= 1'b0;
    waited = 0;
    while (!timed_out && records < tbl_inst.size()) begin
      @(posedge clk);
      waited++;
      if (waited >= DRAIN_LIMIT) begin
        $display("timeout: only %0d of %0d records arrived", records, tbl_inst.size());
        timeouts++;
        timed_out = 1'b1;
      end
    end
    repeat (30) @(posedge clk);  // window for stray extra records
    final_check <= 1'b1;
    @(posedge clk);
    final_check <= 1'b0;
    @(posedge clk);
    $display("errors: %0d from checker, %0d timeouts", chk_errors, timeouts);
    if (chk_errors == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- testbench/wb_checker.sv
module wb_checker (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 inst_valid,
  input  rv_isa_pkg::inst_t    inst_data,
  input  rv_isa_pkg::xlen_t    exp_value,
  input  logic                 inst_credit,
  input  logic                 wb_valid,
  input  rv_isa_pkg::reg_idx_t wb_rd,
  input  rv_isa_pkg::xlen_t    wb_value,
  input  logic                 wb_illegal,
  input  logic                 final_check,
  output int                   errors,
  output int                   records
);
  timeunit 1ns;
  timeprecision 100ps;

  rv_isa_pkg::inst_t    pend_inst [$];  // accepted words, oldest first
  rv_isa_pkg::xlen_t    pend_exp [$];
  rv_isa_pkg::xlen_t    model_regs [32] = '{default: '0};
  int                   err_count = 0;
  int                   rec_count = 0;
  int                   words = 0;
  int                   credits_back = 0;
  rv_isa_pkg::inst_t    word;
  rv_isa_pkg::xlen_t    want;
  rv_isa_pkg::xlen_t    table_val;
  rv_isa_pkg::reg_idx_t rd;
  logic                 illegal;

  assign errors  = err_count;
  assign records = rec_count;

  // RV32I meaning of one word against the model registers
  function automatic logic execute_model(input rv_isa_pkg::inst_t w,
                                         output rv_isa_pkg::xlen_t value);
    rv_isa_pkg::xlen_t  a;
    rv_isa_pkg::xlen_t  b;
    logic signed [31:0] sa;
    logic               alt;
    a     = model_regs[w[19:15]];
    sa    = a;
    b     = '0;
    alt   = 1'b0;
    value = '0;
    case (w[6:0])
      rv_isa_pkg::OPCODE_LUI: begin
        value = {w[31:12], 12'h000};
        return 1'b0;
      end
      rv_isa_pkg::OPCODE_OP: begin
        b   = model_regs[w[24:20]];
        alt = w[30];
      end
      rv_isa_pkg::OPCODE_OP_IMM: begin
        b   = {{20{w[31]}}, w[31:20]};
        alt = w[30] && w[14:12] == 3'b101;  // bit 30 only picks srai
      end
      default: return 1'b1;
    endcase
    case (w[14:12])
      3'b000: value = alt ? a - b : a + b;
      3'b001: value = a << b[4:0];
      3'b010: value = (sa < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: value = (a < b) ? 32'd1 : 32'd0;
      3'b100: value = a ^ b;
      3'b101: begin
        if (alt) begin
          value = sa >>> b[4:0];
        end else begin
          value = a >> b[4:0];
        end
      end
      3'b110: value = a | b;
      default: value = a & b;
    endcase
    return 1'b0;
  endfunction

  always @(posedge clk) begin
    if (arst_n) begin
      if (inst_valid) begin
        pend_inst.push_back(inst_data);
        pend_exp.push_back(exp_value);
        words++;
      end
      if (inst_credit) begin
        credits_back++;
      end
      if (credits_back > words || words - credits_back > engine_cfg_pkg::INTAKE_DEPTH) begin
        $display("input credits out of step at %0t with %0d words sent and %0d credits back",
                 $time, words, credits_back);
        err_count++;
      end
      if (wb_valid) begin
        rec_count++;
        if (pend_inst.size() == 0) begin
          $display("record for x%0d at %0t has no matching instruction", wb_rd, $time);
          err_count++;
        end else begin
          word      = pend_inst.pop_front();
          table_val = pend_exp.pop_front();
          rd        = word[11:7];
          illegal   = execute_model(word, want);
          if (rd == 5'd0) begin
            want = '0;  // a record for x0 reports zero
          end
          if (wb_rd != rd || wb_illegal != illegal) begin
            $display("Error %0t: word %h gave rd x%0d illegal %b, expected x%0d illegal %b",
                     $time, word, wb_rd, wb_illegal, rd, illegal);
            err_count++;
          end else if (!illegal && wb_value != want) begin
            $display("Error %0t: word %h gave x%0d = %h, expected %h",
                     $time, word, rd, wb_value, want);
            err_count++;
          end
          if (!illegal && want != table_val) begin
            $display("Error %0t: model gives %h for word %h, table holds %h",
                     $time, want, word, table_val);
            err_count++;
          end
          if (!illegal && rd != 5'd0) begin
            model_regs[rd] = want;  // x0 stays zero
          end
        end
      end
      if (final_check) begin
        if (pend_inst.size() != 0) begin
          $display("%0d accepted words never produced a record", pend_inst.size());
          err_count++;
        end
        if (credits_back != words) begin
          $display("%0d input credits came back for %0d accepted words", credits_back, words);
          err_count++;
        end
      end
    end
  end

endmodule

//--- vlog.f
hw/rv_isa_pkg.sv
hw/engine_cfg_pkg.sv
hw/inst_intake.sv
hw/reg_file.sv
hw/inst_decode.sv
hw/alu_exec.sv
hw/wb_sender.sv
hw/rv_exec_top.sv
testbench/wb_checker.sv
testbench/tb_rv_exec.sv
